/* src/fscpu_pkg.sv */
package fscpu_pkg;

	// device indexes, also the device's bit in every bitmap
	localparam int dev_motor_lp  = 0;
	localparam int dev_motor_rp  = 1;
	localparam int dev_discharge = 8;

	localparam int dev_num = 9;

	// control commands
	localparam int req_cfg  = 29;
	localparam int req_exe  = 30;
	localparam int req_stop = 31;

	typedef logic [31:0] cmd_t;
	typedef logic [31:0] par_t;

	typedef logic [31:0] speed_t;
	typedef logic [31:0] step_t;

	typedef logic [dev_num-1:0] dev_bmp_t;

	// pwm period, duty and position in period
	typedef logic [15:0] pwm_cnt_t;
	// number of whole periods in a phase
	typedef logic [31:0] pwm_num_t;

	typedef enum logic [2:0] {
		motor_idle,
		motor_issue,
		motor_wait_busy,
		motor_run,
		motor_done
	} motor_state_t;

	typedef enum logic [1:0] {
		pwm_idle,
		pwm_phase0,
		pwm_phase1,
		pwm_done
	} pwm_phase_t;

endpackage

/* src/req_decoder.sv */
`timescale 1ns/1ps

module req_decoder (
	input  logic                clk,
	input  logic                resetn,

	input  logic                req_en,
	input  fscpu_pkg::cmd_t     req_cmd,
	input  fscpu_pkg::par_t     req_par0,
	input  fscpu_pkg::par_t     req_par1,
	input  fscpu_pkg::par_t     req_par2,
	input  fscpu_pkg::par_t     req_par3,

	input  logic                run_done,

	output fscpu_pkg::dev_bmp_t staged_bmp,

	output fscpu_pkg::speed_t   lp_speed,
	output fscpu_pkg::speed_t   rp_speed,
	output fscpu_pkg::step_t    lp_step,
	output fscpu_pkg::step_t    rp_step,
	output logic                lp_dir,
	output logic                rp_dir,

	output fscpu_pkg::pwm_cnt_t duty0,
	output fscpu_pkg::pwm_cnt_t duty1,
	output fscpu_pkg::pwm_cnt_t pwm_period,
	output fscpu_pkg::pwm_num_t count0,
	output fscpu_pkg::pwm_num_t count1
);

	fscpu_pkg::dev_bmp_t staged_base;

	// completion drops whatever was staged for the finished run
	assign staged_base = run_done ? '0 : staged_bmp;

	// left push motor, dir bit high means moving back
	always_ff @(posedge clk) begin
		if (req_en && req_cmd == fscpu_pkg::dev_motor_lp) begin
			lp_speed <= req_par1;
			lp_step  <= req_par2;
			lp_dir   <= req_par0[1];
		end
	end

	// right push motor
	always_ff @(posedge clk) begin
		if (req_en && req_cmd == fscpu_pkg::dev_motor_rp) begin
			rp_speed <= req_par1;
			rp_step  <= req_par2;
			rp_dir   <= req_par0[1];
		end
	end

	// discharge, two duties packed in par0
	always_ff @(posedge clk) begin
		if (!resetn) begin
			count0 <= '0;
			count1 <= '0;
		end else if (req_en && req_cmd == fscpu_pkg::dev_discharge) begin
			count0 <= req_par1;
			count1 <= req_par2;
		end
	end

	always_ff @(posedge clk) begin
		if (req_en && req_cmd == fscpu_pkg::dev_discharge) begin
			duty0 <= req_par0[15:0];
			duty1 <= req_par0[31:16];
		end
	end

	// config, par3 is reserved and ignored
	always_ff @(posedge clk) begin
		if (!resetn) begin
			pwm_period <= '0;
		end else if (req_en && req_cmd == fscpu_pkg::req_cfg) begin
			pwm_period <= req_par0[15:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			staged_bmp <= '0;
		end else if (req_en) begin
			case (req_cmd)
			fscpu_pkg::dev_motor_lp:
				staged_bmp <= staged_base | (fscpu_pkg::dev_bmp_t'(1) << fscpu_pkg::dev_motor_lp);
			fscpu_pkg::dev_motor_rp:
				staged_bmp <= staged_base | (fscpu_pkg::dev_bmp_t'(1) << fscpu_pkg::dev_motor_rp);
			fscpu_pkg::dev_discharge:
				staged_bmp <= staged_base | (fscpu_pkg::dev_bmp_t'(1) << fscpu_pkg::dev_discharge);
			fscpu_pkg::req_cfg, fscpu_pkg::req_exe:
				staged_bmp <= staged_base;
			// stop and unknown commands
			default:
				staged_bmp <= '0;
			endcase
		end else begin
			staged_bmp <= staged_base;
		end
	end

endmodule

/* src/motor_channel.sv */
`timescale 1ns/1ps

module motor_channel (
	input  logic              clk,
	input  logic              resetn,

	input  logic              enable,
	input  fscpu_pkg::speed_t speed_in,
	input  fscpu_pkg::step_t  step_in,
	input  logic              dir_in,

	// stepper driver
	input  logic              state,
	output logic              start,
	output logic              stop,
	output fscpu_pkg::speed_t speed,
	output fscpu_pkg::step_t  step,
	output logic              dir,

	output logic              finished
);

	fscpu_pkg::motor_state_t cur;

	assign finished = (cur == fscpu_pkg::motor_done);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			cur   <= fscpu_pkg::motor_idle;
			start <= 1'b0;
			stop  <= 1'b0;
		end else begin
			start <= 1'b0;
			stop  <= 1'b0;
			case (cur)
			fscpu_pkg::motor_idle: begin
				if (enable) begin
					cur   <= fscpu_pkg::motor_issue;
					start <= 1'b1;
				end
			end
			fscpu_pkg::motor_issue: begin
				cur <= fscpu_pkg::motor_wait_busy;
			end
			fscpu_pkg::motor_wait_busy: begin
				if (!enable) begin
					cur  <= fscpu_pkg::motor_idle;
					stop <= 1'b1;
				end else if (state) begin
					cur <= fscpu_pkg::motor_run;
				end
			end
			fscpu_pkg::motor_run: begin
				if (!enable) begin
					cur  <= fscpu_pkg::motor_idle;
					stop <= 1'b1;
				end else if (!state) begin
					cur <= fscpu_pkg::motor_done;
				end
			end
			fscpu_pkg::motor_done: begin
				// hold until the run is released
				if (!enable)
					cur <= fscpu_pkg::motor_idle;
			end
			default: cur <= fscpu_pkg::motor_idle;
			endcase
		end
	end

	// settings stay put for the whole move
	always_ff @(posedge clk) begin
		if (cur == fscpu_pkg::motor_idle && enable) begin
			speed <= speed_in;
			step  <= step_in;
			dir   <= dir_in;
		end
	end

	a_start_single: assert property (@(posedge clk) disable iff (!resetn)
		start |=> !start);

endmodule

/* src/discharge_pwm.sv */
`timescale 1ns/1ps

module discharge_pwm (
	input  logic                clk,
	input  logic                resetn,

	input  logic                enable,
	input  fscpu_pkg::pwm_cnt_t pwm_period,
	input  fscpu_pkg::pwm_cnt_t duty0,
	input  fscpu_pkg::pwm_cnt_t duty1,
	input  fscpu_pkg::pwm_num_t count0,
	input  fscpu_pkg::pwm_num_t count1,

	output logic                drive,
	output logic                finished
);

	fscpu_pkg::pwm_phase_t phase, phase_nxt;
	fscpu_pkg::pwm_cnt_t   cnt, cnt_nxt;
	fscpu_pkg::pwm_num_t   num, num_nxt;
	logic                  wrap;

	assign wrap     = ({1'b0, cnt} + 17'd1) >= {1'b0, pwm_period};
	assign finished = (phase == fscpu_pkg::pwm_done);

	always_comb begin
		phase_nxt = phase;
		cnt_nxt   = wrap ? '0 : cnt + 16'd1;
		num_nxt   = num;
		case (phase)
		fscpu_pkg::pwm_idle: begin
			cnt_nxt = '0;
			num_nxt = '0;
			// empty phases are skipped
			if (count0 != '0)
				phase_nxt = fscpu_pkg::pwm_phase0;
			else if (count1 != '0)
				phase_nxt = fscpu_pkg::pwm_phase1;
			else
				phase_nxt = fscpu_pkg::pwm_done;
		end
		fscpu_pkg::pwm_phase0: begin
			if (wrap) begin
				num_nxt = num + 32'd1;
				if (num + 32'd1 == count0) begin
					num_nxt   = '0;
					phase_nxt = (count1 != '0) ? fscpu_pkg::pwm_phase1 : fscpu_pkg::pwm_done;
				end
			end
		end
		fscpu_pkg::pwm_phase1: begin
			if (wrap) begin
				num_nxt = num + 32'd1;
				if (num + 32'd1 == count1)
					phase_nxt = fscpu_pkg::pwm_done;
			end
		end
		default: cnt_nxt = '0;
		endcase
		if (!enable)
			phase_nxt = fscpu_pkg::pwm_idle;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			phase <= fscpu_pkg::pwm_idle;
			cnt   <= '0;
			num   <= '0;
			drive <= 1'b0;
		end else begin
			phase <= phase_nxt;
			cnt   <= cnt_nxt;
			num   <= num_nxt;
			drive <= (phase_nxt == fscpu_pkg::pwm_phase0 && cnt_nxt < duty0) ||
				(phase_nxt == fscpu_pkg::pwm_phase1 && cnt_nxt < duty1);
		end
	end

	a_drive_quiet: assert property (@(posedge clk) disable iff (!resetn)
		(phase == fscpu_pkg::pwm_idle || phase == fscpu_pkg::pwm_done) |-> !drive);

endmodule

/* src/done_tracker.sv */
`timescale 1ns/1ps

module done_tracker (
	input  logic                clk,
	input  logic                resetn,

	input  logic                req_en,
	input  fscpu_pkg::cmd_t     req_cmd,
	input  fscpu_pkg::dev_bmp_t staged_bmp,
	input  fscpu_pkg::dev_bmp_t finished_bmp,

	output fscpu_pkg::dev_bmp_t oper_bmp,
	output logic                run_done,
	output logic                req_done
);

	logic exe_acc;
	logic stop_acc;

	assign exe_acc  = req_en && req_cmd == fscpu_pkg::req_exe;
	assign stop_acc = req_en && req_cmd == fscpu_pkg::req_stop;

	// every operating device has finished
	assign run_done = (oper_bmp != '0) && ((finished_bmp & oper_bmp) == oper_bmp);

	always_ff @(posedge clk) begin
		if (!resetn)
			oper_bmp <= '0;
		else if (exe_acc)
			oper_bmp <= staged_bmp;
		else if (stop_acc || run_done)
			oper_bmp <= '0;
	end

	// sticky until the next accepted command
	always_ff @(posedge clk) begin
		if (!resetn)
			req_done <= 1'b0;
		else if (req_en)
			req_done <= 1'b0;
		else if (run_done)
			req_done <= 1'b1;
	end

	a_release_run: assert property (@(posedge clk) disable iff (!resetn)
		run_done && !exe_acc |=> oper_bmp == '0);

endmodule

/* src/fscpu.sv */
`timescale 1ns/1ps

module fscpu (
	input  logic              clk,
	input  logic              resetn,

	input  logic              req_en,
	input  fscpu_pkg::cmd_t   req_cmd,
	input  fscpu_pkg::par_t   req_par0,
	input  fscpu_pkg::par_t   req_par1,
	input  fscpu_pkg::par_t   req_par2,
	input  fscpu_pkg::par_t   req_par3,
	output logic              req_done,

	// left push motor driver
	output logic              ml_start,
	output logic              ml_stop,
	output fscpu_pkg::speed_t ml_speed,
	output fscpu_pkg::step_t  ml_step,
	output logic              ml_dir,
	input  logic              ml_state,

	// right push motor driver
	output logic              mr_start,
	output logic              mr_stop,
	output fscpu_pkg::speed_t mr_speed,
	output fscpu_pkg::step_t  mr_step,
	output logic              mr_dir,
	input  logic              mr_state,

	output logic              discharge_drive
);

	fscpu_pkg::dev_bmp_t staged_bmp;
	fscpu_pkg::dev_bmp_t oper_bmp;
	fscpu_pkg::dev_bmp_t finished_bmp;
	logic                run_done;

	fscpu_pkg::speed_t   lp_speed, rp_speed;
	fscpu_pkg::step_t    lp_step, rp_step;
	logic                lp_dir, rp_dir;
	fscpu_pkg::pwm_cnt_t duty0, duty1, pwm_period;
	fscpu_pkg::pwm_num_t count0, count1;

	logic                lp_finished, rp_finished, dis_finished;

	req_decoder u_req_decoder (
		.clk        (clk),
		.resetn     (resetn),
		.req_en     (req_en),
		.req_cmd    (req_cmd),
		.req_par0   (req_par0),
		.req_par1   (req_par1),
		.req_par2   (req_par2),
		.req_par3   (req_par3),
		.run_done   (run_done),
		.staged_bmp (staged_bmp),
		.lp_speed   (lp_speed),
		.rp_speed   (rp_speed),
		.lp_step    (lp_step),
		.rp_step    (rp_step),
		.lp_dir     (lp_dir),
		.rp_dir     (rp_dir),
		.duty0      (duty0),
		.duty1      (duty1),
		.pwm_period (pwm_period),
		.count0     (count0),
		.count1     (count1)
	);

	motor_channel u_motor_lp (
		.clk      (clk),
		.resetn   (resetn),
		.enable   (oper_bmp[fscpu_pkg::dev_motor_lp]),
		.speed_in (lp_speed),
		.step_in  (lp_step),
		.dir_in   (lp_dir),
		.state    (ml_state),
		.start    (ml_start),
		.stop     (ml_stop),
		.speed    (ml_speed),
		.step     (ml_step),
		.dir      (ml_dir),
		.finished (lp_finished)
	);

	motor_channel u_motor_rp (
		.clk      (clk),
		.resetn   (resetn),
		.enable   (oper_bmp[fscpu_pkg::dev_motor_rp]),
		.speed_in (rp_speed),
		.step_in  (rp_step),
		.dir_in   (rp_dir),
		.state    (mr_state),
		.start    (mr_start),
		.stop     (mr_stop),
		.speed    (mr_speed),
		.step     (mr_step),
		.dir      (mr_dir),
		.finished (rp_finished)
	);

	discharge_pwm u_discharge (
		.clk        (clk),
		.resetn     (resetn),
		.enable     (oper_bmp[fscpu_pkg::dev_discharge]),
		.pwm_period (pwm_period),
		.duty0      (duty0),
		.duty1      (duty1),
		.count0     (count0),
		.count1     (count1),
		.drive      (discharge_drive),
		.finished   (dis_finished)
	);

	// unused device slots never report finished
	always_comb begin
		finished_bmp = '0;
		finished_bmp[fscpu_pkg::dev_motor_lp]  = lp_finished;
		finished_bmp[fscpu_pkg::dev_motor_rp]  = rp_finished;
		finished_bmp[fscpu_pkg::dev_discharge] = dis_finished;
	end

	done_tracker u_done_tracker (
		.clk          (clk),
		.resetn       (resetn),
		.req_en       (req_en),
		.req_cmd      (req_cmd),
		.staged_bmp   (staged_bmp),
		.finished_bmp (finished_bmp),
		.oper_bmp     (oper_bmp),
		.run_done     (run_done),
		.req_done     (req_done)
	);

endmodule

/* tb/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic resetn
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		resetn = 1'b0;
		repeat (16) @(posedge clk);
		resetn <= 1'b1;
	end

endmodule

/* tb/tb_fscpu.sv */
`timescale 1ns/1ps

module tb_fscpu;

	localparam int num_runs    = 40;
	localparam int cycle_limit = num_runs * 3000;

	logic        clk;
	logic        resetn;
	logic        req_en;
	logic [31:0] req_cmd, req_par0, req_par1, req_par2, req_par3;
	logic        req_done;
	logic        ml_start, ml_stop, ml_dir, mr_start, mr_stop, mr_dir;
	logic [31:0] ml_speed, ml_step, mr_speed, mr_step;
	logic        ml_state = 1'b0;
	logic        mr_state = 1'b0;
	logic        discharge_drive;

	logic [31:0] seed = 32'h2247_8ed8;
	int          cyc = 0;
	int          errors = 0;
	int          checks = 0;
	int          accept_cyc;
	int          lp_wait, lp_hold, rp_wait, rp_hold;

	// what the monitor saw since the last execute
	int          lp_starts, rp_starts, lp_stops, rp_stops, drive_cnt;
	int          lp_start_cyc, rp_start_cyc;
	logic        lp_busy, lp_fell, rp_busy, rp_fell;
	logic [31:0] lp_got_speed, lp_got_step, rp_got_speed, rp_got_step;
	logic        lp_got_dir, rp_got_dir;

	clk_gen u_clk_gen (
		.clk    (clk),
		.resetn (resetn)
	);

	fscpu u_fscpu (
		.clk             (clk),
		.resetn          (resetn),
		.req_en          (req_en),
		.req_cmd         (req_cmd),
		.req_par0        (req_par0),
		.req_par1        (req_par1),
		.req_par2        (req_par2),
		.req_par3        (req_par3),
		.req_done        (req_done),
		.ml_start        (ml_start),
		.ml_stop         (ml_stop),
		.ml_speed        (ml_speed),
		.ml_step         (ml_step),
		.ml_dir          (ml_dir),
		.ml_state        (ml_state),
		.mr_start        (mr_start),
		.mr_stop         (mr_stop),
		.mr_speed        (mr_speed),
		.mr_step         (mr_step),
		.mr_dir          (mr_dir),
		.mr_state        (mr_state),
		.discharge_drive (discharge_drive)
	);

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		logic [31:0] r;
		r = next_rand();
		return lo + int'((r >> 8) % 32'(hi - lo + 1));
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("MISMATCH %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= cycle_limit) begin
			$display("run stopped after %0d cycles without finishing", cyc);
			$display(">>> FAIL");
			$finish;
		end
	end

	// stepper driver models, busy a while after start, idle at once on stop
	always @(posedge clk) begin
		if (!resetn || ml_stop) begin
			ml_state <= 1'b0;
			lp_wait = 0;
			lp_hold = 0;
		end else if (ml_start) begin
			lp_wait = rand_range(1, 8);
		end else if (lp_wait != 0) begin
			if (lp_wait == 1) begin
				ml_state <= 1'b1;
				lp_hold = rand_range(1, 20);
			end
			lp_wait--;
		end else if (lp_hold != 0) begin
			if (lp_hold == 1)
				ml_state <= 1'b0;
			lp_hold--;
		end
	end

	always @(posedge clk) begin
		if (!resetn || mr_stop) begin
			mr_state <= 1'b0;
			rp_wait = 0;
			rp_hold = 0;
		end else if (mr_start) begin
			rp_wait = rand_range(1, 8);
		end else if (rp_wait != 0) begin
			if (rp_wait == 1) begin
				mr_state <= 1'b1;
				rp_hold = rand_range(1, 20);
			end
			rp_wait--;
		end else if (rp_hold != 0) begin
			if (rp_hold == 1)
				mr_state <= 1'b0;
			rp_hold--;
		end
	end

	always @(negedge clk) begin
		if (ml_start) begin
			lp_starts++;
			lp_start_cyc = cyc;
			lp_got_speed = ml_speed;
			lp_got_step  = ml_step;
			lp_got_dir   = ml_dir;
		end
		if (mr_start) begin
			rp_starts++;
			rp_start_cyc = cyc;
			rp_got_speed = mr_speed;
			rp_got_step  = mr_step;
			rp_got_dir   = mr_dir;
		end
		if (ml_stop)
			lp_stops++;
		if (mr_stop)
			rp_stops++;
		if (ml_state)
			lp_busy = 1'b1;
		else if (lp_busy)
			lp_fell = 1'b1;
		if (mr_state)
			rp_busy = 1'b1;
		else if (rp_busy)
			rp_fell = 1'b1;
		if (discharge_drive && !req_done)
			drive_cnt++;
	end

	task automatic clear_monitor();
		lp_starts = 0;
		rp_starts = 0;
		lp_stops  = 0;
		rp_stops  = 0;
		drive_cnt = 0;
		lp_busy   = 1'b0;
		lp_fell   = 1'b0;
		rp_busy   = 1'b0;
		rp_fell   = 1'b0;
	endtask

	// one accepted command, returns at the falling edge after acceptance
	task automatic send_cmd(input logic [31:0] cmd, input logic [31:0] p0,
		input logic [31:0] p1, input logic [31:0] p2);
		@(posedge clk);
		req_en   <= 1'b1;
		req_cmd  <= cmd;
		req_par0 <= p0;
		req_par1 <= p1;
		req_par2 <= p2;
		req_par3 <= next_rand();
		@(posedge clk);
		req_en <= 1'b0;
		@(negedge clk);
		accept_cyc = cyc;
	endtask

	task automatic normal_run(input int run);
		logic        lp_on, rp_on, pwm_on;
		int          period, d0, d1, c0, c1;
		logic [31:0] lp_sp, lp_st, lp_p0, rp_sp, rp_st, rp_p0;
		lp_on  = next_rand() > 32'h8000_0000;
		rp_on  = next_rand() > 32'h8000_0000;
		pwm_on = next_rand() > 32'h8000_0000;
		if (!lp_on && !rp_on && !pwm_on)
			lp_on = 1'b1;
		if (pwm_on) begin
			period = rand_range(4, 16);
			d0 = rand_range(0, period);
			d1 = rand_range(0, period);
			c0 = rand_range(0, 5);
			c1 = rand_range(0, 5);
			send_cmd(32'(fscpu_pkg::req_cfg), 32'(period), next_rand(), next_rand());
			send_cmd(32'(fscpu_pkg::dev_discharge), {16'(d1), 16'(d0)}, 32'(c0), 32'(c1));
		end
		if (lp_on) begin
			lp_sp = next_rand();
			lp_st = next_rand();
			lp_p0 = next_rand();
			send_cmd(32'(fscpu_pkg::dev_motor_lp), lp_p0, lp_sp, lp_st);
		end
		if (rp_on) begin
			rp_sp = next_rand();
			rp_st = next_rand();
			rp_p0 = next_rand();
			send_cmd(32'(fscpu_pkg::dev_motor_rp), rp_p0, rp_sp, rp_st);
		end
		clear_monitor();
		send_cmd(32'(fscpu_pkg::req_exe), next_rand(), next_rand(), next_rand());
		while (!req_done)
			@(negedge clk);
		check($sformatf("run%0d lp_starts", run), lp_on ? 1 : 0, lp_starts);
		check($sformatf("run%0d rp_starts", run), rp_on ? 1 : 0, rp_starts);
		check($sformatf("run%0d stops", run), 0, lp_stops + rp_stops);
		if (lp_on) begin
			check($sformatf("run%0d lp_start_cyc", run), accept_cyc + 1, lp_start_cyc);
			check($sformatf("run%0d lp_speed", run), lp_sp, lp_got_speed);
			check($sformatf("run%0d lp_step", run), lp_st, lp_got_step);
			check($sformatf("run%0d lp_dir", run), lp_p0[1], lp_got_dir);
			check($sformatf("run%0d lp_state_fell", run), 1, lp_fell);
		end
		if (rp_on) begin
			check($sformatf("run%0d rp_start_cyc", run), accept_cyc + 1, rp_start_cyc);
			check($sformatf("run%0d rp_speed", run), rp_sp, rp_got_speed);
			check($sformatf("run%0d rp_step", run), rp_st, rp_got_step);
			check($sformatf("run%0d rp_dir", run), rp_p0[1], rp_got_dir);
			check($sformatf("run%0d rp_state_fell", run), 1, rp_fell);
		end
		check($sformatf("run%0d drive_cycles", run), pwm_on ? d0 * c0 + d1 * c1 : 0, drive_cnt);
	endtask

	task automatic stop_run(input int run);
		logic right;
		right = next_rand() > 32'h8000_0000;
		send_cmd(right ? 32'(fscpu_pkg::dev_motor_rp) : 32'(fscpu_pkg::dev_motor_lp),
			next_rand(), next_rand(), next_rand());
		clear_monitor();
		send_cmd(32'(fscpu_pkg::req_exe), next_rand(), next_rand(), next_rand());
		while (!(right ? mr_start : ml_start))
			@(negedge clk);
		send_cmd(32'(fscpu_pkg::req_stop), next_rand(), next_rand(), next_rand());
		repeat (10) @(negedge clk);
		check($sformatf("run%0d lp_stops", run), right ? 0 : 1, lp_stops);
		check($sformatf("run%0d rp_stops", run), right ? 1 : 0, rp_stops);
		check($sformatf("run%0d done_after_stop", run), 0, req_done);
		// nothing is staged any more
		clear_monitor();
		send_cmd(32'(fscpu_pkg::req_exe), next_rand(), next_rand(), next_rand());
		repeat (40) @(negedge clk);
		check($sformatf("run%0d empty_starts", run), 0, lp_starts + rp_starts);
		check($sformatf("run%0d empty_done", run), 0, req_done);
	endtask

	initial begin
		req_en   = 1'b0;
		req_cmd  = '0;
		req_par0 = '0;
		req_par1 = '0;
		req_par2 = '0;
		req_par3 = '0;
		@(posedge resetn);
		@(negedge clk);
		check("reset req_done", 0, req_done);
		check("reset start", 0, ml_start | mr_start);
		check("reset stop", 0, ml_stop | mr_stop);
		check("reset drive", 0, discharge_drive);
		for (int run = 0; run < num_runs; run++) begin
			if (rand_range(0, 4) == 0)
				stop_run(run);
			else
				normal_run(run);
			while (ml_state || mr_state)
				@(negedge clk);
			repeat (3) @(negedge clk);
		end
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* fscpu.f */
src/fscpu_pkg.sv
src/req_decoder.sv
src/motor_channel.sv
src/discharge_pwm.sv
src/done_tracker.sv
src/fscpu.sv
tb/clk_gen.sv
tb/tb_fscpu.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f fscpu.f --top-module tb_fscpu -o sim_fscpu &&
./obj_dir/sim_fscpu | grep ">>> PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
